/* filelist.f */
+incdir+.
vp_sys_pkg.sv
vp_io_pkg.sv
vp_sys_config.sv
vp_clk_enables.sv
vp_cart_mapper.sv
vp_input_encoder.sv
vp_palette.sv
vp_glue_top.sv
tb_vp_glue.sv

/* Bender.yml */
package:
  name: vp_glue

export_include_dirs:
  - .

sources:
  - files:
      - vp_sys_pkg.sv
      - vp_io_pkg.sv
      - vp_sys_config.sv
      - vp_clk_enables.sv
      - vp_cart_mapper.sv
      - vp_input_encoder.sv
      - vp_palette.sv
      - vp_glue_top.sv
  - target: test
    files:
      - tb_vp_glue.sv

/* tb_vp_glue.sv */
////////////////////////////////////////
// Directed testbench for the glue top
// Clock, reset, LFSR, check tasks and
// one task per tested behaviour
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_consts.svh"

module tb_vp_glue;

	logic                      clk_sys;
	logic                      reset;
	vp_sys_pkg::sys_settings_t settings_i;
	logic                      download_i;
	logic                      load_wr_i;
	vp_sys_pkg::load_index_e   load_index_i;
	logic [`VP_ROM_AW-1:0]     load_addr_i;
	logic [`VP_CART_AW-1:0]    cart_addr_i;
	logic                      bank0_i;
	logic                      bank1_i;
	logic                      cart_cs_n_i;
	logic                      psen_n_i;
	logic [`VP_CHAR_AW-1:0]    char_addr_i;
	vp_io_pkg::ps2_key_t       ps2_key_i;
	vp_io_pkg::joy_pad_t       joy_a_i;
	vp_io_pkg::joy_pad_t       joy_b_i;
	logic                      r_i;
	logic                      g_i;
	logic                      b_i;
	logic                      luma_i;
	vp_sys_pkg::sys_settings_t settings_o;
	logic                      console_reset_o;
	logic                      cpu_en_o;
	logic                      vdc_en_o;
	logic [`VP_ROM_AW-1:0]     rom_addr_o;
	logic                      rom_we_o;
	logic                      rom_rd_o;
	logic [`VP_CHAR_AW-1:0]    char_addr_o;
	logic                      char_we_o;
	vp_io_pkg::key_event_t     key_event_o;
	vp_io_pkg::console_pad_t   pad_o;
	vp_io_pkg::pixel_t         pixel_o;

	int          errors;
	int          checks;
	logic [15:0] lfsr_q;

	// Kept keys of the console keymap
	localparam logic [7:0] KEY_CODE [20] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45,
		8'h29, 8'h79, 8'h7B, 8'h7C, 8'h4A, 8'h55, 8'h1F, 8'h27, 8'h5A, 8'h66
	};
	localparam logic [7:0] KEY_CHAR [20] = '{
		"1", "2", "3", "4", "5", "6", "7", "8", "9", "0",
		" ", "+", "-", "*", "/", "=", 8'h11, 8'h12, 8'h0A, 8'h08
	};

	// Reference palettes indexed by {r, g, b, luma}
	localparam logic [23:0] NTSC_REF [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};
	localparam logic [23:0] PAL_REF [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	vp_glue_top dut_i (.*);

	// 100 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		logic [15:0] v;
		v = rand_bits(1);
		return v[0];
	endfunction

	// Drive slot 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	////////////////////////////////////////
	// Check tasks
	////////////////////////////////////////
	task automatic check_addr(input string name, input logic [`VP_ROM_AW-1:0] exp,
		input logic [`VP_ROM_AW-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_event(input string name, input vp_io_pkg::key_event_t exp,
		input vp_io_pkg::key_event_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected stb %b rel %b ascii %h actual stb %b rel %b ascii %h",
				name, exp.stb, exp.released, exp.ascii, act.stb, act.released, act.ascii);
		end
	endtask

	task automatic check_pad(input string name, input vp_io_pkg::console_pad_t exp,
		input vp_io_pkg::console_pad_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %b actual %b at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_pixel(input string name, input vp_io_pkg::pixel_t exp,
		input vp_io_pkg::pixel_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_settings(input string name, input vp_sys_pkg::sys_settings_t exp,
		input vp_sys_pkg::sys_settings_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %b actual %b at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("FAIL %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	// Single strobe or level
	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %b actual %b at %0t", name, exp, act, $time);
		end
	endtask

	////////////////////////////////////////
	// Waits with their own timeouts
	////////////////////////////////////////
	task automatic wait_enable(input logic vdc, output int n);
		n = -1;
		for (int i = 1; i <= 32 && n < 0; i++) begin
			@(negedge clk_sys);
			if ((vdc ? vdc_en_o : cpu_en_o) === 1'b1)
				n = i;
		end
		if (n < 0) begin
			errors++;
			$display("Timeout: no %s clock enable pulse within 32 cycles",
				vdc ? "VDC" : "CPU");
		end
	endtask

	// Counts rising edges until the key strobe shows
	task automatic wait_event(input string name, output int n);
		n = -1;
		for (int i = 1; i <= 16 && n < 0; i++) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			if (key_event_o.stb === 1'b1)
				n = i;
		end
		if (n < 0) begin
			errors++;
			$display("Timeout: %s produced no key event within 16 cycles", name);
		end
	endtask

	////////////////////////////////////////
	// Expected values from the mapping rules
	////////////////////////////////////////
	function automatic vp_sys_pkg::cart_size_e size_of(input int nbytes);
		if (nbytes == `VP_SIZE_4K)
			return vp_sys_pkg::SIZE_4K;
		if (nbytes == `VP_SIZE_8K)
			return vp_sys_pkg::SIZE_8K;
		if (nbytes == `VP_SIZE_16K)
			return vp_sys_pkg::SIZE_16K;
		return vp_sys_pkg::SIZE_2K;
	endfunction

	// A10 only survives in the 16K layout
	function automatic logic [`VP_ROM_AW-1:0] expect_map(input vp_sys_pkg::cart_size_e sz,
		input logic xrom, input logic [11:0] a, input logic b0, input logic b1);
		if (xrom)
			return {2'b00, a};
		case (sz)
			vp_sys_pkg::SIZE_4K:  return {2'b00, b0, a[11], a[9:0]};
			vp_sys_pkg::SIZE_8K:  return {1'b0, b1, b0, a[11], a[9:0]};
			vp_sys_pkg::SIZE_16K: return {b1, b0, a};
			default:              return {3'b000, a[11], a[9:0]};
		endcase
	endfunction

	// Lowest pressed button wins and bit 9 is key 0
	function automatic logic [7:0] joy_char(input logic [9:0] mask);
		for (int i = 0; i < 10; i++) begin
			if (mask[i])
				return (i == 9) ? "0" : 8'("1" + i);
		end
		return 8'h00;
	endfunction

	////////////////////////////////////////
	// Cartridge helpers
	////////////////////////////////////////
	task automatic run_download(input string name, input vp_sys_pkg::load_index_e idx,
		input int nbytes);
		next_cycle();
		download_i   = 1'b1;
		load_index_i = idx;
		load_wr_i    = 1'b0;
		for (int i = 0; i < nbytes; i++) begin
			next_cycle();
			load_wr_i   = 1'b1;
			load_addr_i = 14'(i);
			@(negedge clk_sys);
			check_flag({name, " rom_we"}, 1'b1, rom_we_o);
			check_flag({name, " char_we"}, 1'b0, char_we_o);
			check_flag({name, " console reset"}, 1'b1, console_reset_o);
			check_addr({name, " load addr"}, 14'(i), rom_addr_o);
		end
		next_cycle();
		load_wr_i  = 1'b0;
		download_i = 1'b0;
	endtask

	task automatic check_map(input string name, input vp_sys_pkg::cart_size_e sz,
		input logic xrom, input int n);
		logic [15:0] r;
		logic        rd;
		for (int i = 0; i < n; i++) begin
			next_cycle();
			r           = rand_bits(12);
			cart_addr_i = r[11:0];
			bank0_i     = rand_bit();
			bank1_i     = rand_bit();
			cart_cs_n_i = rand_bit();
			psen_n_i    = rand_bit();
			r           = rand_bits(9);
			char_addr_i = r[8:0];
			@(negedge clk_sys);
			check_addr(name, expect_map(sz, xrom, cart_addr_i, bank0_i, bank1_i), rom_addr_o);
			// XROM reads also outside the select window
			rd = xrom ? (~(cart_cs_n_i & bank0_i) & psen_n_i) : ~psen_n_i;
			check_flag({name, " rom_rd"}, rd, rom_rd_o);
			// Console character address passes straight through
			check_addr({name, " char addr"}, {5'b0, char_addr_i}, {5'b0, char_addr_o});
		end
	endtask

	////////////////////////////////////////
	// Key helpers
	////////////////////////////////////////
	task automatic press_ps2(input string name, input logic [7:0] code, input logic pressed,
		input logic [7:0] ascii);
		vp_io_pkg::key_event_t exp;
		int                    n;
		next_cycle();
		ps2_key_i.toggle   = ~ps2_key_i.toggle;
		ps2_key_i.pressed  = pressed;
		ps2_key_i.extended = 1'b0;
		ps2_key_i.code     = code;
		wait_event(name, n);
		check_count({name, " latency"}, 2, n);
		exp.stb      = 1'b1;
		exp.released = ~pressed;
		exp.ascii    = ascii;
		check_event(name, exp, key_event_o);
		@(negedge clk_sys);
		check_flag({name, " single strobe"}, 1'b0, key_event_o.stb);
	endtask

	task automatic press_joy(input string name, input logic use_b, input logic [9:0] mask);
		vp_io_pkg::key_event_t exp;
		int                    n;
		next_cycle();
		if (use_b)
			joy_b_i.num = mask;
		else
			joy_a_i.num = mask;
		wait_event(name, n);
		check_count({name, " press latency"}, 2, n);
		exp.stb      = 1'b1;
		exp.released = 1'b0;
		exp.ascii    = joy_char(mask);
		check_event({name, " press"}, exp, key_event_o);
		// All buttons up again
		next_cycle();
		joy_a_i.num = '0;
		joy_b_i.num = '0;
		wait_event(name, n);
		check_count({name, " release latency"}, 2, n);
		check_flag({name, " released"}, 1'b1, key_event_o.released);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	task automatic test_clk_enables();
		int n;
		int resets;
		wait_enable(1'b0, n);
		wait_enable(1'b0, n);
		check_count("ntsc cpu period", 8, n);
		wait_enable(1'b1, n);
		wait_enable(1'b1, n);
		check_count("ntsc vdc period", 6, n);
		next_cycle();
		settings_i.video_std = vp_sys_pkg::STD_PAL;
		resets = 0;
		repeat (20) begin
			@(negedge clk_sys);
			if (console_reset_o === 1'b1)
				resets++;
		end
		check_count("std change console reset", 1, resets);
		wait_enable(1'b0, n);
		wait_enable(1'b0, n);
		check_count("pal cpu period", 12, n);
		wait_enable(1'b1, n);
		wait_enable(1'b1, n);
		check_count("pal vdc period", 10, n);
	endtask

	task automatic test_cart_sizes();
		run_download("cart 4k", vp_sys_pkg::IDX_CART_A, `VP_SIZE_4K);
		check_map("cart 4k map", size_of(`VP_SIZE_4K), 1'b0, 32);
		run_download("cart 8k", vp_sys_pkg::IDX_CART_A, `VP_SIZE_8K);
		check_map("cart 8k map", size_of(`VP_SIZE_8K), 1'b0, 32);
		run_download("cart 16k", vp_sys_pkg::IDX_CART_A, `VP_SIZE_16K);
		check_map("cart 16k map", size_of(`VP_SIZE_16K), 1'b0, 32);
		// One byte over 4K falls back to 2K
		run_download("cart odd", vp_sys_pkg::IDX_CART_A, 4097);
		check_map("cart odd map", size_of(4097), 1'b0, 32);
	endtask

	task automatic test_xrom_charset();
		int          n_char;
		int          n_rom;
		logic [15:0] r;
		run_download("xrom", vp_sys_pkg::IDX_XROM, 64);
		check_map("xrom map", vp_sys_pkg::SIZE_2K, 1'b1, 32);
		next_cycle();
		download_i   = 1'b1;
		load_index_i = vp_sys_pkg::IDX_CHARSET;
		load_wr_i    = 1'b0;
		n_char = 0;
		n_rom  = 0;
		// Writes on every other cycle
		for (int i = 0; i < 12; i++) begin
			next_cycle();
			load_wr_i   = (i % 2 == 1);
			r           = rand_bits(14);
			load_addr_i = r[13:0];
			@(negedge clk_sys);
			n_char += char_we_o;
			n_rom  += rom_we_o;
			check_addr("charset addr", {5'b0, load_addr_i[8:0]}, {5'b0, char_addr_o});
		end
		next_cycle();
		load_wr_i  = 1'b0;
		download_i = 1'b0;
		check_count("charset char_we pulses", 6, n_char);
		check_count("charset rom_we pulses", 0, n_rom);
		check_map("after charset map", vp_sys_pkg::SIZE_2K, 1'b0, 8);
	endtask

	task automatic test_ps2_keys();
		logic [15:0] r;
		int          idx;
		for (int k = 0; k < 12; k++) begin
			r   = rand_bits(5);
			idx = int'(r[4:0]) % 20;
			press_ps2("ps2 kept key", KEY_CODE[idx], rand_bit(), KEY_CHAR[idx]);
		end
		press_ps2("ps2 unlisted key", 8'h1C, 1'b1, 8'h00);
	endtask

	task automatic test_joy_numbers();
		logic [15:0] r;
		logic [9:0]  mask;
		for (int k = 0; k < 8; k++) begin
			r    = rand_bits(10);
			mask = (r[9:0] == '0) ? 10'h001 : r[9:0];
			press_joy("joy number", rand_bit(), mask);
		end
	endtask

	task automatic test_pads(input logic swap);
		vp_io_pkg::console_pad_t exp;
		vp_io_pkg::joy_pad_t     p1;
		vp_io_pkg::joy_pad_t     p2;
		logic [15:0]             r;
		next_cycle();
		settings_i.joy_swap = swap;
		for (int k = 0; k < 12; k++) begin
			next_cycle();
			r       = rand_bits(12);
			joy_a_i = {10'b0, r[5:0]};
			joy_b_i = {10'b0, r[11:6]};
			// Player A sits on bit 1
			p1 = swap ? joy_b_i : joy_a_i;
			p2 = swap ? joy_a_i : joy_b_i;
			exp.up_n     = {~p1.up, ~p2.up};
			exp.down_n   = {~p1.down, ~p2.down};
			exp.left_n   = {~p1.left, ~p2.left};
			exp.right_n  = {~p1.right, ~p2.right};
			exp.action_n = {~p1.action, ~p2.action};
			exp.reset_n  = ~(joy_a_i.reset & joy_b_i.reset);
			@(negedge clk_sys);
			check_pad(swap ? "pad swapped" : "pad direct", exp, pad_o);
		end
		next_cycle();
		joy_a_i = '0;
		joy_b_i = '0;
	endtask

	task automatic test_colours(input vp_sys_pkg::video_std_e std);
		logic [23:0]               ref_rgb;
		vp_sys_pkg::sys_settings_t prev;
		next_cycle();
		prev = settings_i;
		settings_i.palette = std;
		// Settings word takes one clock to show
		@(negedge clk_sys);
		check_settings("settings hold", prev, settings_o);
		next_cycle();
		check_settings("settings registered", settings_i, settings_o);
		for (int idx = 0; idx < 16; idx++) begin
			next_cycle();
			{r_i, g_i, b_i, luma_i} = 4'(idx);
			ref_rgb = (std == vp_sys_pkg::STD_PAL) ? PAL_REF[idx] : NTSC_REF[idx];
			@(negedge clk_sys);
			check_pixel(std == vp_sys_pkg::STD_PAL ? "pal colour" : "ntsc colour",
				vp_io_pkg::pixel_t'(ref_rgb), pixel_o);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		errors       = 0;
		checks       = 0;
		lfsr_q       = 16'd41;
		reset        = 1'b1;
		settings_i   = '0;
		download_i   = 1'b0;
		load_wr_i    = 1'b0;
		load_index_i = vp_sys_pkg::IDX_CART_A;
		load_addr_i  = '0;
		cart_addr_i  = '0;
		bank0_i      = 1'b0;
		bank1_i      = 1'b0;
		cart_cs_n_i  = 1'b1;
		psen_n_i     = 1'b1;
		char_addr_i  = '0;
		ps2_key_i    = '0;
		joy_a_i      = '0;
		joy_b_i      = '0;
		{r_i, g_i, b_i, luma_i} = 4'b0000;
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		test_clk_enables();
		test_cart_sizes();
		test_xrom_charset();
		test_ps2_keys();
		test_joy_numbers();
		test_pads(1'b0);
		test_pads(1'b1);
		test_colours(vp_sys_pkg::STD_NTSC);
		test_colours(vp_sys_pkg::STD_PAL);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* vp_glue_top.sv */
////////////////////////////////////////
// Videopac board glue, top level
// Settings, clock enables, cartridge
// mapper, input encoder and palette
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_consts.svh"

module vp_glue_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  vp_sys_pkg::sys_settings_t settings_i,
	input  logic                      download_i,
	input  logic                      load_wr_i,
	input  vp_sys_pkg::load_index_e   load_index_i,
	input  logic [`VP_ROM_AW-1:0]     load_addr_i,
	input  logic [`VP_CART_AW-1:0]    cart_addr_i,
	input  logic                      bank0_i,
	input  logic                      bank1_i,
	input  logic                      cart_cs_n_i,
	input  logic                      psen_n_i,
	input  logic [`VP_CHAR_AW-1:0]    char_addr_i,
	input  vp_io_pkg::ps2_key_t       ps2_key_i,
	input  vp_io_pkg::joy_pad_t       joy_a_i,
	input  vp_io_pkg::joy_pad_t       joy_b_i,
	input  logic                      r_i,
	input  logic                      g_i,
	input  logic                      b_i,
	input  logic                      luma_i,
	output vp_sys_pkg::sys_settings_t settings_o,
	output logic                      console_reset_o,
	output logic                      cpu_en_o,
	output logic                      vdc_en_o,
	output logic [`VP_ROM_AW-1:0]     rom_addr_o,
	output logic                      rom_we_o,
	output logic                      rom_rd_o,
	output logic [`VP_CHAR_AW-1:0]    char_addr_o,
	output logic                      char_we_o,
	output vp_io_pkg::key_event_t     key_event_o,
	output vp_io_pkg::console_pad_t   pad_o,
	output vp_io_pkg::pixel_t         pixel_o
);

	vp_sys_config sys_config_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.settings_i      (settings_i),
		.download_i      (download_i),
		.settings_o      (settings_o),
		.console_reset_o (console_reset_o)
	);

	// Console reset also realigns the dividers
	vp_clk_enables clk_enables_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.video_std_i (settings_o.video_std),
		.restart_i   (console_reset_o),
		.cpu_en_o    (cpu_en_o),
		.vdc_en_o    (vdc_en_o)
	);

	vp_cart_mapper cart_mapper_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download_i   (download_i),
		.load_wr_i    (load_wr_i),
		.load_index_i (load_index_i),
		.load_addr_i  (load_addr_i),
		.cart_addr_i  (cart_addr_i),
		.bank0_i      (bank0_i),
		.bank1_i      (bank1_i),
		.cart_cs_n_i  (cart_cs_n_i),
		.psen_n_i     (psen_n_i),
		.char_addr_i  (char_addr_i),
		.rom_addr_o   (rom_addr_o),
		.rom_we_o     (rom_we_o),
		.rom_rd_o     (rom_rd_o),
		.char_addr_o  (char_addr_o),
		.char_we_o    (char_we_o)
	);

	vp_input_encoder input_encoder_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key_i   (ps2_key_i),
		.joy_a_i     (joy_a_i),
		.joy_b_i     (joy_b_i),
		.joy_swap_i  (settings_o.joy_swap),
		.key_event_o (key_event_o),
		.pad_o       (pad_o)
	);

	vp_palette palette_i (
		.video_std_i (settings_o.palette),
		.r_i         (r_i),
		.g_i         (g_i),
		.b_i         (b_i),
		.luma_i      (luma_i),
		.pixel_o     (pixel_o)
	);

endmodule

/* vp_palette.sv */
////////////////////////////////////////
// NTSC and PAL colour lookup
////////////////////////////////////////
`timescale 1ns/1ps

module vp_palette (
	input  vp_sys_pkg::video_std_e video_std_i,
	input  logic                   r_i,
	input  logic                   g_i,
	input  logic                   b_i,
	input  logic                   luma_i,
	output vp_io_pkg::pixel_t      pixel_o
);

	// Calibrated palette, pairs of dark then luma
	localparam logic [23:0] LUT_NTSC [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	// Saturated palette
	localparam logic [23:0] LUT_PAL [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	logic [3:0]  idx;
	logic [23:0] colour;

	// Red is the top index bit
	assign idx = {r_i, g_i, b_i, luma_i};

	assign colour = (video_std_i == vp_sys_pkg::STD_PAL) ? LUT_PAL[idx] : LUT_NTSC[idx];

	assign pixel_o = vp_io_pkg::pixel_t'(colour);

endmodule

/* vp_input_encoder.sv */
////////////////////////////////////////
// Keypad event encoder for PS/2 and
// joystick number buttons, joystick
// vectors towards the console
////////////////////////////////////////
`timescale 1ns/1ps

module vp_input_encoder (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  vp_io_pkg::ps2_key_t       ps2_key_i,
	input  vp_io_pkg::joy_pad_t       joy_a_i,
	input  vp_io_pkg::joy_pad_t       joy_b_i,
	input  logic                      joy_swap_i,
	output vp_io_pkg::key_event_t     key_event_o,
	output vp_io_pkg::console_pad_t   pad_o
);

	vp_io_pkg::joy_pad_t joy_p1;
	vp_io_pkg::joy_pad_t joy_p2;
	logic [9:0]          joy_num;
	logic [9:0]          joy_num_q;
	logic                toggle_q;
	logic                ps2_chg;
	logic                ps2_chg_q;
	logic                ps2_rel_q;
	logic                joy_chg_q;
	logic                joy_rel_q;
	logic [7:0]          ps2_ascii;
	logic [7:0]          ps2_ascii_q;
	logic [7:0]          joy_ascii;
	logic [7:0]          joy_ascii_q;

	assign joy_num = joy_a_i.num | joy_b_i.num;
	assign ps2_chg = (ps2_key_i.toggle != toggle_q);

	// Console keymap table, extended prefix ignored
	always_comb begin
		case (ps2_key_i.code)
			8'h16:   ps2_ascii = "1";
			8'h1E:   ps2_ascii = "2";
			8'h26:   ps2_ascii = "3";
			8'h25:   ps2_ascii = "4";
			8'h2E:   ps2_ascii = "5";
			8'h36:   ps2_ascii = "6";
			8'h3D:   ps2_ascii = "7";
			8'h3E:   ps2_ascii = "8";
			8'h46:   ps2_ascii = "9";
			8'h45:   ps2_ascii = "0";
			8'h29:   ps2_ascii = " ";
			8'h79:   ps2_ascii = "+";
			8'h7B:   ps2_ascii = "-";
			8'h7C:   ps2_ascii = "*";
			8'h4A:   ps2_ascii = "/";
			8'h55:   ps2_ascii = "=";
			// Left and right GUI act as yes and no
			8'h1F:   ps2_ascii = 8'h11;
			8'h27:   ps2_ascii = 8'h12;
			8'h5A:   ps2_ascii = 8'h0A;
			8'h66:   ps2_ascii = 8'h08;
			default: ps2_ascii = 8'h00;
		endcase
	end

	// Lowest pressed button wins, bit 9 is key 0
	always_comb begin
		joy_ascii = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (joy_num[i]) begin
				joy_ascii = (i == 9) ? 8'h30 : 8'h31 + 8'(i);
			end
		end
	end

	////////////////////////////////////////
	// Edge detect, then event register
	////////////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q    <= 1'b0;
			joy_num_q   <= '0;
			ps2_chg_q   <= 1'b0;
			ps2_rel_q   <= 1'b1;
			joy_chg_q   <= 1'b0;
			joy_rel_q   <= 1'b1;
			key_event_o <= '0;
		end else begin
			toggle_q  <= ps2_key_i.toggle;
			joy_num_q <= joy_num;
			ps2_chg_q <= ps2_chg;
			ps2_rel_q <= ~ps2_key_i.pressed;
			joy_chg_q <= |(joy_num ^ joy_num_q);
			joy_rel_q <= (joy_num == '0);
			// PS/2 takes the slot when both change together
			key_event_o.stb      <= ps2_chg_q | joy_chg_q;
			key_event_o.ascii    <= ps2_chg_q ? ps2_ascii_q : joy_ascii_q;
			key_event_o.released <= joy_rel_q & (ps2_rel_q | ~ps2_chg_q);
		end
	end

	// Character latches
	always_ff @(posedge clk_sys) begin
		if (ps2_chg) begin
			ps2_ascii_q <= ps2_ascii;
		end
		if (joy_num != '0) begin
			joy_ascii_q <= joy_ascii;
		end
	end

	////////////////////////////////////////
	// Joystick vectors, low when pressed
	////////////////////////////////////////
	assign joy_p1 = joy_swap_i ? joy_b_i : joy_a_i;
	assign joy_p2 = joy_swap_i ? joy_a_i : joy_b_i;

	assign pad_o.up_n     = {~joy_p1.up, ~joy_p2.up};
	assign pad_o.down_n   = {~joy_p1.down, ~joy_p2.down};
	assign pad_o.left_n   = {~joy_p1.left, ~joy_p2.left};
	assign pad_o.right_n  = {~joy_p1.right, ~joy_p2.right};
	assign pad_o.action_n = {~joy_p1.action, ~joy_p2.action};
	// Console reset needs both players
	assign pad_o.reset_n  = ~(joy_p1.reset & joy_p2.reset);

endmodule

/* vp_cart_mapper.sv */
////////////////////////////////////////
// Cartridge download tracking, load write
// steering and banked address mapping
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_consts.svh"

module vp_cart_mapper (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    download_i,
	input  logic                    load_wr_i,
	input  vp_sys_pkg::load_index_e load_index_i,
	input  logic [`VP_ROM_AW-1:0]   load_addr_i,
	input  logic [`VP_CART_AW-1:0]  cart_addr_i,
	input  logic                    bank0_i,
	input  logic                    bank1_i,
	input  logic                    cart_cs_n_i,
	input  logic                    psen_n_i,
	input  logic [`VP_CHAR_AW-1:0]  char_addr_i,
	output logic [`VP_ROM_AW-1:0]   rom_addr_o,
	output logic                    rom_we_o,
	output logic                    rom_rd_o,
	output logic [`VP_CHAR_AW-1:0]  char_addr_o,
	output logic                    char_we_o
);

	localparam logic [`VP_SIZE_W-1:0] BYTES_4K  = `VP_SIZE_4K;
	localparam logic [`VP_SIZE_W-1:0] BYTES_8K  = `VP_SIZE_8K;
	localparam logic [`VP_SIZE_W-1:0] BYTES_16K = `VP_SIZE_16K;

	logic                   download_q;
	logic                   xrom_q;
	logic [`VP_SIZE_W-1:0]  size_q;
	vp_sys_pkg::cart_size_e cart_size;
	logic [`VP_ROM_AW-1:0]  map_addr;
	logic                   to_char;

	////////////////////////////////////////
	// Download tracking
	////////////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_q <= 1'b0;
			xrom_q     <= 1'b0;
			size_q     <= '0;
		end else begin
			download_q <= download_i;
			// First download cycle restarts the count
			if (download_i && !download_q) begin
				size_q <= '0;
				xrom_q <= (load_index_i == vp_sys_pkg::IDX_XROM);
			end else if (download_i && load_wr_i) begin
				size_q <= size_q + 1'b1;
			end
		end
	end

	// Only exact sizes pick a banked layout
	always_comb begin
		case (size_q)
			BYTES_4K:  cart_size = vp_sys_pkg::SIZE_4K;
			BYTES_8K:  cart_size = vp_sys_pkg::SIZE_8K;
			BYTES_16K: cart_size = vp_sys_pkg::SIZE_16K;
			default:   cart_size = vp_sys_pkg::SIZE_2K;
		endcase
	end

	////////////////////////////////////////
	// Address map, A10 unused below 16K
	////////////////////////////////////////
	always_comb begin
		if (xrom_q) begin
			map_addr = {2'b00, cart_addr_i};
		end else begin
			case (cart_size)
				vp_sys_pkg::SIZE_4K:
					map_addr = {2'b00, bank0_i, cart_addr_i[11], cart_addr_i[9:0]};
				vp_sys_pkg::SIZE_8K:
					map_addr = {1'b0, bank1_i, bank0_i, cart_addr_i[11], cart_addr_i[9:0]};
				vp_sys_pkg::SIZE_16K:
					map_addr = {bank1_i, bank0_i, cart_addr_i};
				default:
					map_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
			endcase
		end
	end

	// Indices 0..2 land in cartridge ROM, 3 in char ROM
	assign to_char   = (load_index_i == vp_sys_pkg::IDX_CHARSET);
	assign rom_we_o  = load_wr_i & ~to_char;
	assign char_we_o = load_wr_i & to_char;

	assign rom_addr_o  = (download_i && !to_char) ? load_addr_i : map_addr;
	assign char_addr_o = (download_i && to_char) ? load_addr_i[`VP_CHAR_AW-1:0] : char_addr_i;

	// XROM also answers outside the cartridge select window
	assign rom_rd_o = xrom_q ? (~(cart_cs_n_i & bank0_i) & psen_n_i) : ~psen_n_i;

endmodule

/* vp_clk_enables.sv */
////////////////////////////////////////
// CPU and VDC clock-enable pulses
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_consts.svh"

module vp_clk_enables (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  vp_sys_pkg::video_std_e video_std_i,
	input  logic                   restart_i,
	output logic                   cpu_en_o,
	output logic                   vdc_en_o
);

	localparam logic [`VP_DIV_W-1:0] CPU_TERM_NTSC = `VP_CPU_TERM_NTSC;
	localparam logic [`VP_DIV_W-1:0] CPU_TERM_PAL  = `VP_CPU_TERM_PAL;
	localparam logic [`VP_DIV_W-1:0] VDC_TERM_NTSC = `VP_VDC_TERM_NTSC;
	localparam logic [`VP_DIV_W-1:0] VDC_TERM_PAL  = `VP_VDC_TERM_PAL;

	logic [`VP_DIV_W-1:0] cpu_cnt_q;
	logic [`VP_DIV_W-1:0] vdc_cnt_q;
	logic [`VP_DIV_W-1:0] cpu_term;
	logic [`VP_DIV_W-1:0] vdc_term;
	logic                 is_pal;

	// NTSC divides by 8 and 6, PAL by 12 and 10
	assign is_pal   = (video_std_i == vp_sys_pkg::STD_PAL);
	assign cpu_term = is_pal ? CPU_TERM_PAL : CPU_TERM_NTSC;
	assign vdc_term = is_pal ? VDC_TERM_PAL : VDC_TERM_NTSC;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt_q <= '0;
			vdc_cnt_q <= '0;
			cpu_en_o  <= 1'b0;
			vdc_en_o  <= 1'b0;
		end else if (restart_i) begin
			// Restart lines both dividers up again
			cpu_cnt_q <= '0;
			vdc_cnt_q <= '0;
			cpu_en_o  <= 1'b0;
			vdc_en_o  <= 1'b0;
		end else begin
			// Wrap on >= so a PAL to NTSC switch never overruns
			cpu_en_o  <= (cpu_cnt_q >= cpu_term);
			cpu_cnt_q <= (cpu_cnt_q >= cpu_term) ? '0 : cpu_cnt_q + 1'b1;
			vdc_en_o  <= (vdc_cnt_q >= vdc_term);
			vdc_cnt_q <= (vdc_cnt_q >= vdc_term) ? '0 : vdc_cnt_q + 1'b1;
		end
	end

endmodule

/* vp_sys_config.sv */
////////////////////////////////////////
// Settings register with console reset
// on video standard change or download
////////////////////////////////////////
`timescale 1ns/1ps

module vp_sys_config (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  vp_sys_pkg::sys_settings_t settings_i,
	input  logic                      download_i,
	output vp_sys_pkg::sys_settings_t settings_o,
	output logic                      console_reset_o
);

	vp_sys_pkg::sys_settings_t settings_q;
	vp_sys_pkg::video_std_e    std_prev_q;
	logic                      std_chg_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			settings_q <= '0;
			std_prev_q <= vp_sys_pkg::STD_NTSC;
			std_chg_q  <= 1'b0;
		end else begin
			settings_q <= settings_i;
			// Previous standard trails the registered one by a cycle
			std_prev_q <= settings_q.video_std;
			std_chg_q  <= (settings_q.video_std != std_prev_q);
		end
	end

	assign settings_o = settings_q;

	// Console held in reset for the whole download
	assign console_reset_o = std_chg_q | download_i;

endmodule

/* vp_io_pkg.sv */
////////////////////////////////////////
// Input and video types
// PS/2 key, key event, joystick pads
// and 24-bit pixel
////////////////////////////////////////
package vp_io_pkg;

	// Host PS/2 key word, toggle flips per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// Event towards the console keymap
	typedef struct packed {
		logic       stb;
		logic       released;
		logic [7:0] ascii;
	} key_event_t;

	// Host joystick, high when pressed
	// num holds keys 1..9 then 0
	typedef struct packed {
		logic [9:0] num;
		logic       reset;
		logic       action;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_pad_t;

	// Console side, active low, bit 1 player A
	typedef struct packed {
		logic [1:0] up_n;
		logic [1:0] down_n;
		logic [1:0] left_n;
		logic [1:0] right_n;
		logic [1:0] action_n;
		logic       reset_n;
	} console_pad_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

endpackage

/* vp_sys_pkg.sv */
////////////////////////////////////////
// System-side types
// Video standard, settings word, load
// index and decoded cartridge size
////////////////////////////////////////
package vp_sys_pkg;

	// Odyssey2 timing or Videopac timing
	typedef enum logic {
		STD_NTSC = 1'b0,
		STD_PAL  = 1'b1
	} video_std_e;

	// Registered system settings, three bits
	typedef struct packed {
		video_std_e video_std;
		video_std_e palette;
		logic       joy_swap;
	} sys_settings_t;

	// Download target selected by the host
	typedef enum logic [1:0] {
		IDX_CART_A  = 2'd0,
		IDX_CART_B  = 2'd1,
		IDX_XROM    = 2'd2,
		IDX_CHARSET = 2'd3
	} load_index_e;

	// Cartridge layout decoded from the byte count
	typedef enum logic [1:0] {
		SIZE_2K  = 2'd0,
		SIZE_4K  = 2'd1,
		SIZE_8K  = 2'd2,
		SIZE_16K = 2'd3
	} cart_size_e;

endpackage

/* vp_consts.svh */
////////////////////////////////////////
// Constants for the Videopac glue logic
// Divider terminal counts, cartridge size
// thresholds and address widths
////////////////////////////////////////
`ifndef VP_CONSTS_SVH
`define VP_CONSTS_SVH

// Last count of the CPU divider per standard
`define VP_CPU_TERM_NTSC 7
`define VP_CPU_TERM_PAL 11

// Last count of the VDC divider per standard
`define VP_VDC_TERM_NTSC 5
`define VP_VDC_TERM_PAL 9
`define VP_DIV_W 4

// Download byte counts that select a banked layout
`define VP_SIZE_4K 4096
`define VP_SIZE_8K 8192
`define VP_SIZE_16K 16384
`define VP_SIZE_W 16

// ROM, character ROM and cartridge bus widths
`define VP_ROM_AW 14
`define VP_CHAR_AW 9
`define VP_CART_AW 12

`endif
